// File: design/cmac_params.svh
// size and pipeline macros for the cmac slice, included by the package, the RTL and the testbench
`ifndef CMAC_PARAMS_SVH
`define CMAC_PARAMS_SVH

// ==============================
// atom geometry
// ==============================

// lanes per atom
`define CMAC_ATOMC 8
// bits per element, signed
`define CMAC_BPE 8

// ==============================
// result and retiming
// ==============================

// 16 bit product plus 3 bits of growth for 8 lanes
`define CMAC_RESULT_WIDTH 19
// register stages behind the adder
`define CMAC_OUT_RETIMING 2

`endif

// File: design/cmac_pkg.sv
// shared vector types and the lane non-zero helper, imported by every cmac module
`include "cmac_params.svh"

package cmac_pkg;

  // packed atom, lane i sits in element slot i from the lsb
  typedef logic [`CMAC_ATOMC*`CMAC_BPE-1:0] cmac_vec_t;

  // one bit per lane, used for valid masks and nz flags
  typedef logic [`CMAC_ATOMC-1:0] cmac_lane_t;

  // two's complement dot product
  typedef logic [`CMAC_RESULT_WIDTH-1:0] cmac_result_t;

  // per-lane non-zero detect, evaluated where the operand is registered
  function automatic cmac_lane_t cmac_lane_nz(cmac_vec_t vec);
    cmac_lane_t nz;
    for (int i = 0; i < `CMAC_ATOMC; i++) begin
      // any set bit means the element is non-zero
      nz[i] = |vec[i*`CMAC_BPE +: `CMAC_BPE];
    end
    return nz;
  endfunction

endpackage

// File: design/cmac_actv.sv
// data activation stage, registers each incoming atom and its lane flags for the mac stage
`timescale 1ns/1ps

module cmac_actv (
  input  logic                nvdla_core_clk,
  input  logic                rst,
  input  logic                dat_pvld,
  input  cmac_pkg::cmac_vec_t  dat_data,
  input  cmac_pkg::cmac_lane_t dat_mask,
  output logic                dat_actv_strb,
  output cmac_pkg::cmac_lane_t dat_actv_pvld,
  output cmac_pkg::cmac_lane_t dat_actv_nz,
  output cmac_pkg::cmac_vec_t  dat_actv_data
);

  import cmac_pkg::*;

  // ==============================
  // control path
  // ==============================

  // strobe follows dat_pvld by one cycle
  // lane valids only live for the cycle of the atom
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      dat_actv_strb <= 1'b0;
      dat_actv_pvld <= '0;
    end else begin
      dat_actv_strb <= dat_pvld;
      if (dat_pvld) begin
        dat_actv_pvld <= dat_mask;
      end else begin
        // drop all lanes when no atom arrives
        dat_actv_pvld <= '0;
      end
    end
  end

  // ==============================
  // payload path
  // ==============================

  // nz flags computed here so the mac can skip zero operands
  cmac_lane_t dat_nz;

  assign dat_nz = cmac_lane_nz(dat_data);

  // data and flags hold between atoms
  always_ff @(posedge nvdla_core_clk) begin
    if (dat_pvld) begin
      dat_actv_data <= dat_data;
      dat_actv_nz   <= dat_nz;
    end
  end

endmodule

// File: design/cmac_wt_buf.sv
// weight shadow buffer, captures one weight atom on a load strobe and presents it as levels
`timescale 1ns/1ps

module cmac_wt_buf (
  input  logic                nvdla_core_clk,
  input  logic                rst,
  input  logic                wt_load,
  input  cmac_pkg::cmac_vec_t  wt_data,
  input  cmac_pkg::cmac_lane_t wt_mask,
  output cmac_pkg::cmac_lane_t wt_actv_pvld,
  output cmac_pkg::cmac_lane_t wt_actv_nz,
  output cmac_pkg::cmac_vec_t  wt_actv_data
);

  import cmac_pkg::*;

  // ==============================
  // lane valid mask
  // ==============================

  // weights stay invalid until the first load
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      wt_actv_pvld <= '0;
    end else if (wt_load) begin
      wt_actv_pvld <= wt_mask;
    end
  end

  // ==============================
  // weight atom and nz flags
  // ==============================

  // nz worked out once per load, not once per data atom
  cmac_lane_t wt_nz;

  assign wt_nz = cmac_lane_nz(wt_data);

  // new weights appear one cycle after wt_load
  // an atom sampled in the load cycle meets them in the mac
  always_ff @(posedge nvdla_core_clk) begin
    if (wt_load) begin
      wt_actv_data <= wt_data;
      wt_actv_nz   <= wt_nz;
    end
  end

endmodule

// File: design/cmac_mac.sv
// mac stage that sums the gated signed lane products into one result and retimes it behind valid
`timescale 1ns/1ps
`include "cmac_params.svh"

module cmac_mac (
  input  logic                 nvdla_core_clk,
  input  logic                 rst,
  input  logic                 dat_actv_strb,
  input  cmac_pkg::cmac_lane_t  dat_actv_pvld,
  input  cmac_pkg::cmac_lane_t  dat_actv_nz,
  input  cmac_pkg::cmac_vec_t   dat_actv_data,
  input  cmac_pkg::cmac_lane_t  wt_actv_pvld,
  input  cmac_pkg::cmac_lane_t  wt_actv_nz,
  input  cmac_pkg::cmac_vec_t   wt_actv_data,
  output logic                 mac_out_pvld,
  output cmac_pkg::cmac_result_t mac_out_data
);

  import cmac_pkg::*;

  localparam int BPE    = `CMAC_BPE;
  localparam int PROD_W = 2 * `CMAC_BPE;
  localparam int RES_W  = `CMAC_RESULT_WIDTH;
  localparam int RTM    = `CMAC_OUT_RETIMING;

  // ==============================
  // lane products
  // ==============================

  // a lane counts only with both operands valid and non-zero
  cmac_lane_t   op_en;
  // products already sign extended to result width
  cmac_result_t prod_ext [`CMAC_ATOMC];

  for (genvar i = 0; i < `CMAC_ATOMC; i++) begin : g_lane
    logic signed [BPE-1:0]    dat_lane;
    logic signed [BPE-1:0]    wt_lane;
    logic signed [PROD_W-1:0] prod_raw;
    logic signed [PROD_W-1:0] prod;

    // unpack slot i
    assign dat_lane = dat_actv_data[i*BPE +: BPE];
    assign wt_lane  = wt_actv_data[i*BPE +: BPE];

    assign op_en[i] = dat_actv_pvld[i] & dat_actv_nz[i] & wt_actv_pvld[i] & wt_actv_nz[i];

    // signed 8 by 8 multiply at full product width
    assign prod_raw = dat_lane * wt_lane;

    // gated lanes contribute zero
    assign prod = op_en[i] ? prod_raw : '0;

    assign prod_ext[i] = {{(RES_W - PROD_W){prod[PROD_W-1]}}, prod};
  end

  // ==============================
  // lane sum
  // ==============================

  // combinational sum in front of the first retiming stage
  cmac_result_t sum_out;

  always_comb begin
    sum_out = '0;
    for (int i = 0; i < `CMAC_ATOMC; i++) begin
      sum_out = sum_out + prod_ext[i];
    end
  end

  // ==============================
  // retiming pipeline
  // ==============================

  logic [RTM-1:0] pp_pvld;
  cmac_result_t   pp_data [RTM];

  // valid shifts every cycle with stage 0 fed by the atom strobe
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      pp_pvld <= '0;
    end else begin
      pp_pvld[0] <= dat_actv_strb;
      for (int k = 1; k < RTM; k++) begin
        pp_pvld[k] <= pp_pvld[k-1];
      end
    end
  end

  // each data stage loads only when the stage ahead of it is valid
  // so the output holds its last result between atoms
  always_ff @(posedge nvdla_core_clk) begin
    if (dat_actv_strb) begin
      pp_data[0] <= sum_out;
    end
    for (int k = 1; k < RTM; k++) begin
      if (pp_pvld[k-1]) begin
        pp_data[k] <= pp_data[k-1];
      end
    end
  end

  assign mac_out_pvld = pp_pvld[RTM-1];
  assign mac_out_data = pp_data[RTM-1];

endmodule

// File: design/cmac_core.sv
// cmac slice top, ties the data activation stage and weight buffer to the mac stage
`timescale 1ns/1ps

module cmac_core (
  input  logic                 nvdla_core_clk,
  input  logic                 rst,
  // weight load side
  input  logic                 wt_load,
  input  cmac_pkg::cmac_vec_t   wt_data,
  input  cmac_pkg::cmac_lane_t  wt_mask,
  // data atom stream
  input  logic                 dat_pvld,
  input  cmac_pkg::cmac_vec_t   dat_data,
  input  cmac_pkg::cmac_lane_t  dat_mask,
  // result, three cycles behind dat_pvld
  output logic                 mac_out_pvld,
  output cmac_pkg::cmac_result_t mac_out_data
);

  import cmac_pkg::*;

  // ==============================
  // internal nets
  // ==============================

  // activation stage to mac
  logic       dat_actv_strb;
  cmac_lane_t dat_actv_pvld;
  cmac_lane_t dat_actv_nz;
  cmac_vec_t  dat_actv_data;

  // weight buffer to mac, held until the next load
  cmac_lane_t wt_actv_pvld;
  cmac_lane_t wt_actv_nz;
  cmac_vec_t  wt_actv_data;

  // ==============================
  // instances
  // ==============================

  cmac_actv i_actv (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_pvld       (dat_pvld),
    .dat_data       (dat_data),
    .dat_mask       (dat_mask),
    .dat_actv_strb  (dat_actv_strb),
    .dat_actv_pvld  (dat_actv_pvld),
    .dat_actv_nz    (dat_actv_nz),
    .dat_actv_data  (dat_actv_data)
  );

  cmac_wt_buf i_wt_buf (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .wt_load        (wt_load),
    .wt_data        (wt_data),
    .wt_mask        (wt_mask),
    .wt_actv_pvld   (wt_actv_pvld),
    .wt_actv_nz     (wt_actv_nz),
    .wt_actv_data   (wt_actv_data)
  );

  cmac_mac i_mac (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_actv_strb  (dat_actv_strb),
    .dat_actv_pvld  (dat_actv_pvld),
    .dat_actv_nz    (dat_actv_nz),
    .dat_actv_data  (dat_actv_data),
    .wt_actv_pvld   (wt_actv_pvld),
    .wt_actv_nz     (wt_actv_nz),
    .wt_actv_data   (wt_actv_data),
    .mac_out_pvld   (mac_out_pvld),
    .mac_out_data   (mac_out_data)
  );

endmodule

// File: testbench/tb_clkgen.sv
// clock and reset source for the cmac testbench, 40 ns clock with reset held for 10 cycles
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 10;

  // free running clock, starts low
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // synchronous reset released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: testbench/tb_cmac_core.sv
// testbench for cmac_core, loads weights, streams atoms and checks every result by assertion
`timescale 1ns/1ps
`include "cmac_params.svh"

module tb_cmac_core;

  import cmac_pkg::*;

  localparam int BPE            = `CMAC_BPE;
  localparam int LANES          = `CMAC_ATOMC;
  localparam int RESULT_TIMEOUT = 100;
  localparam int RESET_TIMEOUT  = 50;

  logic         nvdla_core_clk;
  logic         rst;
  logic         wt_load;
  cmac_vec_t    wt_data;
  cmac_lane_t   wt_mask;
  logic         dat_pvld;
  cmac_vec_t    dat_data;
  cmac_lane_t   dat_mask;
  logic         mac_out_pvld;
  cmac_result_t mac_out_data;

  // ==============================
  // scoreboard state
  // ==============================

  integer       seed = 71402;
  int           err_count = 0;
  int           pass_tests = 0;
  int           fail_tests = 0;
  int           sent_count = 0;
  int           result_count = 0;
  int           cyc = 0;
  // weights the DUT holds once the last load has landed
  cmac_vec_t    ref_wt_data = '0;
  cmac_lane_t   ref_wt_mask = '0;
  // expected sums in arrival order, with the cycle each atom was driven
  cmac_result_t exp_q[$];
  int           tag_q[$];
  cmac_result_t exp_head = '0;
  int           exp_tag = 0;
  // dat_pvld history, bit 2 is three cycles back
  logic [2:0]   pvld_hist = '0;

  tb_clkgen i_clkgen (
    .clk (nvdla_core_clk),
    .rst (rst)
  );

  cmac_core i_dut (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .wt_load        (wt_load),
    .wt_data        (wt_data),
    .wt_mask        (wt_mask),
    .dat_pvld       (dat_pvld),
    .dat_data       (dat_data),
    .dat_mask       (dat_mask),
    .mac_out_pvld   (mac_out_pvld),
    .mac_out_data   (mac_out_data)
  );

  always @(posedge nvdla_core_clk) begin
    cyc       <= cyc + 1;
    pvld_hist <= {pvld_hist[1:0], dat_pvld};
  end

  // pop the expected head while the output is stable, the assertion reads it on the next edge
  always @(negedge nvdla_core_clk) begin
    if (!rst && mac_out_pvld) begin
      if (exp_q.size() == 0) begin
        $display("result appeared with no atom outstanding");
        err_count = err_count + 1;
      end else begin
        exp_head = exp_q.pop_front();
        exp_tag  = tag_q.pop_front();
      end
      result_count = result_count + 1;
    end
  end

  // ==============================
  // checks
  // ==============================

  a_out_timing: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    mac_out_pvld == pvld_hist[2])
    else begin
      $display("Mismatch mac_out_pvld expected %h actual %h",
               $sampled(pvld_hist[2]), $sampled(mac_out_pvld));
      err_count = err_count + 1;
    end

  a_out_data: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    mac_out_pvld |-> (mac_out_data == exp_head))
    else begin
      $display("Mismatch mac_out_data expected %h actual %h (atom driven at cycle %0d)",
               $sampled(exp_head), $sampled(mac_out_data), exp_tag);
      err_count = err_count + 1;
    end

  // ==============================
  // reference model and stimulus
  // ==============================

  // lane rule: both operands valid and non-zero, signed product, summed at result width
  function automatic cmac_result_t calc_dot(cmac_vec_t d, cmac_lane_t dm,
                                            cmac_vec_t w, cmac_lane_t wm);
    logic signed [BPE-1:0] de;
    logic signed [BPE-1:0] we;
    int                    acc;
    acc = 0;
    for (int i = 0; i < LANES; i++) begin
      de = d[i*BPE +: BPE];
      we = w[i*BPE +: BPE];
      if (dm[i] && wm[i] && de != '0 && we != '0) begin
        acc = acc + int'(de) * int'(we);
      end
    end
    return acc[`CMAC_RESULT_WIDTH-1:0];
  endfunction

  function automatic cmac_vec_t rand_vec();
    cmac_vec_t   v;
    logic [31:0] r;
    for (int i = 0; i < LANES; i++) begin
      r = $random(seed);
      v[i*BPE +: BPE] = r[BPE-1:0];
    end
    return v;
  endfunction

  function automatic cmac_lane_t rand_lane();
    logic [31:0] r;
    r = $random(seed);
    return r[LANES-1:0];
  endfunction

  // force the selected lanes to zero so the nz path gets exercised
  function automatic cmac_vec_t zero_lanes(cmac_vec_t v, cmac_lane_t sel);
    cmac_vec_t z;
    z = v;
    for (int i = 0; i < LANES; i++) begin
      if (sel[i]) begin
        z[i*BPE +: BPE] = '0;
      end
    end
    return z;
  endfunction

  // one rising edge of stimulus, the model sees a load before an atom of the same cycle
  task automatic drive_cycle(input logic pvld, input cmac_vec_t d, input cmac_lane_t dm,
                             input logic ld, input cmac_vec_t w, input cmac_lane_t wm);
    @(posedge nvdla_core_clk);
    dat_pvld <= pvld;
    dat_data <= d;
    dat_mask <= dm;
    wt_load  <= ld;
    wt_data  <= w;
    wt_mask  <= wm;
    if (ld) begin
      ref_wt_data = w;
      ref_wt_mask = wm;
    end
    if (pvld) begin
      exp_q.push_back(calc_dot(d, dm, ref_wt_data, ref_wt_mask));
      tag_q.push_back(cyc);
      sent_count = sent_count + 1;
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (result_count < sent_count && n < RESULT_TIMEOUT) begin
      @(posedge nvdla_core_clk);
      n = n + 1;
    end
    if (result_count < sent_count) begin
      $display("timeout: %0d results still missing after %0d cycles",
               sent_count - result_count, n);
      err_count = err_count + 1;
    end
  endtask

  task automatic send_single(input cmac_vec_t d, input cmac_lane_t dm);
    drive_cycle(1'b1, d, dm, 1'b0, '0, '0);
    idle_cycle();
    wait_results();
  endtask

  task automatic load_weights(input cmac_vec_t w, input cmac_lane_t wm);
    drive_cycle(1'b0, '0, '0, 1'b1, w, wm);
  endtask

  task automatic end_test(input string name, input int errs_before);
    // let the assertions of the last result fire first
    @(negedge nvdla_core_clk);
    if (err_count == errs_before) begin
      pass_tests = pass_tests + 1;
      $display("[%s] passed", name);
    end else begin
      fail_tests = fail_tests + 1;
      $display("[%s] failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // ==============================
  // tests
  // ==============================

  task automatic test_reset_quiet();
    int e0;
    int n;
    e0 = err_count;
    n = 0;
    @(negedge nvdla_core_clk);
    while (rst && n < RESET_TIMEOUT) begin
      assert (mac_out_pvld == 1'b0) else begin
        $display("Mismatch mac_out_pvld expected 0 actual %h during reset", mac_out_pvld);
        err_count = err_count + 1;
      end
      @(negedge nvdla_core_clk);
      n = n + 1;
    end
    if (rst) begin
      $display("reset was never released");
      err_count = err_count + 1;
    end
    repeat (20) begin
      idle_cycle();
      @(negedge nvdla_core_clk);
      assert (mac_out_pvld == 1'b0) else begin
        $display("Mismatch mac_out_pvld expected 0 actual %h while idle", mac_out_pvld);
        err_count = err_count + 1;
      end
    end
    // no weights loaded yet, so the sum must be zero
    send_single(rand_vec(), '1);
    end_test("reset_quiet", e0);
  endtask

  task automatic test_full_dot();
    int e0;
    e0 = err_count;
    load_weights(rand_vec(), '1);
    for (int k = 0; k < 10; k++) begin
      send_single(rand_vec(), '1);
    end
    end_test("full_dot", e0);
  endtask

  task automatic test_masking();
    int e0;
    e0 = err_count;
    for (int k = 0; k < 20; k++) begin
      load_weights(zero_lanes(rand_vec(), rand_lane()), rand_lane());
      send_single(zero_lanes(rand_vec(), rand_lane()), rand_lane());
    end
    end_test("masking", e0);
  endtask

  task automatic test_stream();
    int e0;
    e0 = err_count;
    load_weights(rand_vec(), '1);
    for (int k = 0; k < 30; k++) begin
      drive_cycle(1'b1, rand_vec(), '1, 1'b0, '0, '0);
    end
    idle_cycle();
    wait_results();
    end_test("stream", e0);
  endtask

  task automatic test_reload();
    int e0;
    e0 = err_count;
    load_weights(rand_vec(), '1);
    // reloads land on atoms 4 and 6 while earlier atoms are still in flight
    for (int k = 0; k < 8; k++) begin
      drive_cycle(1'b1, rand_vec(), '1, (k == 4) || (k == 6), rand_vec(), rand_lane());
    end
    idle_cycle();
    wait_results();
    end_test("reload", e0);
  endtask

  task automatic test_extremes();
    int e0;
    e0 = err_count;
    assert (calc_dot({LANES{8'h80}}, '1, {LANES{8'h80}}, '1) == 19'h20000) else begin
      $display("reference model gives the wrong value for -128 times -128");
      err_count = err_count + 1;
    end
    load_weights({LANES{8'h80}}, '1);
    send_single({LANES{8'h80}}, '1);
    // -130048 at 19 bits
    assert (calc_dot({LANES{8'h80}}, '1, {LANES{8'h7f}}, '1) == 19'h60400) else begin
      $display("reference model gives the wrong value for -128 times 127");
      err_count = err_count + 1;
    end
    load_weights({LANES{8'h7f}}, '1);
    send_single({LANES{8'h80}}, '1);
    end_test("extremes", e0);
  endtask

  initial begin
    wt_load  = 1'b0;
    wt_data  = '0;
    wt_mask  = '0;
    dat_pvld = 1'b0;
    dat_data = '0;
    dat_mask = '0;
    test_reset_quiet();
    test_full_dot();
    test_masking();
    test_stream();
    test_reload();
    test_extremes();
    $display("tests passed %0d failed %0d, atoms %0d results %0d errors %0d",
             pass_tests, fail_tests, sent_count, result_count, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: cmac_core.f
+incdir+design
design/cmac_pkg.sv
design/cmac_actv.sv
design/cmac_wt_buf.sv
design/cmac_mac.sv
design/cmac_core.sv
testbench/tb_clkgen.sv
testbench/tb_cmac_core.sv

// File: Makefile
# Verilator flow for the cmac_core testbench

TOP := tb_cmac_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cmac_core.f

# the run fails when the log holds the fail message
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cmac_core.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
